// ==== bench/proc_props.sv ====
// port checks bound to every proc_top instance
// assumes a synchronous active-high reset held for at least one cycle

`timescale 1ns/1ns
`include "proc_defs.svh"

module proc_props (
  input logic                  clk,
  input logic                  reset,
  input logic [`PROC_XLEN-1:0] imemAddr,
  input logic                  dmemReq,
  input logic                  dmemWrite,
  input logic                  toMngrValid
);

  // a store is always a memory request
  writeIsReq: assert property (@(posedge clk) disable iff (reset) dmemWrite |-> dmemReq)
    else $error("dmemWrite high without dmemReq");

  pcAligned: assert property (@(posedge clk) disable iff (reset) imemAddr[1:0] == 2'b00)
    else $error("imemAddr not word aligned");

  // W register cleared by reset, nothing reaches W one cycle later either
  quietAfterReset: assert property (@(posedge clk)
    ($past(reset) || $past(reset, 2)) |-> !toMngrValid)
    else $error("toMngrValid high during or right after reset");

endmodule

bind proc_top proc_props props (
  .clk         (clk),
  .reset       (reset),
  .imemAddr    (imemAddr),
  .dmemReq     (dmemReq),
  .dmemWrite   (dmemWrite),
  .toMngrValid (toMngrValid)
);

// ==== bench/proc_tb.sv ====
// instruction fetch is combinational from imemAddr
// unused instruction words read as NOP
// data reads are captured on the rising edge and returned on the falling edge

`timescale 1ns/1ns
`include "proc_defs.svh"

module proc_tb;
  import proc_pkg::*;

  localparam int IMEM_WORDS  = 256;
  localparam int OUT_TIMEOUT = 60;

  logic                  clk;
  logic                  reset;
  logic [`PROC_XLEN-1:0] imemAddr;
  logic [`PROC_XLEN-1:0] imemData;
  logic                  dmemReq;
  logic                  dmemWrite;
  logic [`PROC_XLEN-1:0] dmemAddr;
  logic [`PROC_XLEN-1:0] dmemWriteData;
  logic [`PROC_XLEN-1:0] dmemReadData = '0;
  logic                  toMngrValid;
  logic [`PROC_XLEN-1:0] toMngrData;

  logic [31:0] imem [IMEM_WORDS];
  logic [31:0] dmem [256];
  logic [31:0] imemIdx;
  logic [7:0]  readIdx = '0;
  logic [7:0]  progLen;
  logic [31:0] lfsrState = 32'haeef_ab4c;

  proc_top UUT (
    .clk           (clk),
    .reset         (reset),
    .imemAddr      (imemAddr),
    .imemData      (imemData),
    .dmemReq       (dmemReq),
    .dmemWrite     (dmemWrite),
    .dmemAddr      (dmemAddr),
    .dmemWriteData (dmemWriteData),
    .dmemReadData  (dmemReadData),
    .toMngrValid   (toMngrValid),
    .toMngrData    (toMngrData)
  );

  initial begin
    clk = 1'b0;
    forever #10 clk = ~clk;
  end

  // ------------------------------------------------------------
  // memory models
  // ------------------------------------------------------------

  always_comb begin
    imemIdx = (imemAddr - `PROC_RESET_PC) >> 2;
    if (imemIdx < IMEM_WORDS) begin
      imemData = imem[imemIdx[7:0]];
    end else begin
      imemData = '0;
    end
  end

  always @(posedge clk) begin
    if (dmemReq) begin
      if (dmemWrite) begin
        dmem[dmemAddr[9:2]] <= dmemWriteData;
      end else begin
        readIdx <= dmemAddr[9:2];
      end
    end
  end

  // load data is valid while the load sits in M
  always @(negedge clk) begin
    dmemReadData <= dmem[readIdx];
  end

  // ------------------------------------------------------------
  // helpers
  // ------------------------------------------------------------

  // galois LFSR for x^32 + x^22 + x^2 + x + 1 stepped once per bit
  function automatic logic [31:0] randBits(input int n);
    logic [31:0] value;
    value = '0;
    for (int i = 0; i < n; i++) begin
      value     = {value[30:0], lfsrState[0]};
      lfsrState = lfsrState[0] ? ((lfsrState >> 1) ^ 32'h8020_0003) : (lfsrState >> 1);
    end
    return value;
  endfunction

  function automatic logic [31:0] sext16(input logic [15:0] v);
    return {{16{v[15]}}, v};
  endfunction

  // opcode, rd, rs, rt, imm
  function automatic logic [31:0] encode(input opcode_t op, input logic [3:0] rd,
                                         input logic [3:0] rs, input logic [3:0] rt,
                                         input logic [15:0] imm);
    return {op, rd, rs, rt, imm};
  endfunction

  task automatic stopRun(input string msg);
    $display("%s", msg);
    $display("ERRORS FOUND");
    $fatal(1);
  endtask

  task automatic failValue(input string name, input logic [31:0] got,
                           input logic [31:0] expected);
    stopRun($sformatf("Fail %s got 0x%h expected 0x%h", name, got, expected));
  endtask

  task automatic clearProgram();
    imem    = '{default: '0};
    progLen = '0;
  endtask

  task automatic emit(input logic [31:0] word);
    imem[progLen] = word;
    progLen       = progLen + 8'd1;
  endtask

  task automatic resetCore();
    @(negedge clk);
    reset = 1'b1;
    repeat (10) @(negedge clk);
    reset = 1'b0;
  endtask

  // waits for the next OUT and checks its value
  task automatic expectOut(input logic [31:0] expected, input string what);
    int cyc;
    cyc = 0;
    while (!toMngrValid && cyc < OUT_TIMEOUT) begin
      @(negedge clk);
      cyc++;
    end
    assert (toMngrValid) else stopRun($sformatf("timed out waiting for OUT of %s", what));
    assert (toMngrData === expected) else failValue("toMngrData", toMngrData, expected);
    @(negedge clk);
  endtask

  task automatic checkQuiet(input int cycles);
    for (int i = 0; i < cycles; i++) begin
      assert (!toMngrValid) else stopRun("toMngrValid pulsed with no OUT left to run");
      @(negedge clk);
    end
  endtask

  // ------------------------------------------------------------
  // directed tests
  // ------------------------------------------------------------

  task automatic resetState();
    clearProgram();
    resetCore();
    assert (imemAddr === `PROC_RESET_PC) else failValue("imemAddr", imemAddr, `PROC_RESET_PC);
    for (int i = 0; i < 30; i++) begin
      assert (!toMngrValid) else stopRun("toMngrValid pulsed while memory holds only NOPs");
      assert (!dmemReq) else stopRun("dmemReq raised while memory holds only NOPs");
      @(negedge clk);
    end
  endtask

  task automatic aluChain();
    logic [31:0] a;
    logic [31:0] b;
    logic [31:0] r3;
    logic [31:0] r4;
    logic [31:0] r5;
    logic [31:0] r6;
    a  = randBits(16);
    b  = randBits(16);
    r3 = sext16(a[15:0]) + sext16(b[15:0]);
    r4 = r3 - sext16(a[15:0]);
    r5 = r4 & sext16(a[15:0]);
    r6 = r5 | r3;
    clearProgram();
    emit(encode(OP_ADDI, 4'd1, 4'd0, 4'd0, a[15:0]));
    emit(encode(OP_ADDI, 4'd2, 4'd0, 4'd0, b[15:0]));
    // r1 from M, r2 from X
    emit(encode(OP_ADD, 4'd3, 4'd1, 4'd2, 16'd0));
    // r3 from X, r1 from W
    emit(encode(OP_SUB, 4'd4, 4'd3, 4'd1, 16'd0));
    emit(encode(OP_AND, 4'd5, 4'd4, 4'd1, 16'd0));
    emit(encode(OP_OR, 4'd6, 4'd5, 4'd3, 16'd0));
    emit(encode(OP_OUT, 4'd0, 4'd6, 4'd0, 16'd0));
    emit(encode(OP_OUT, 4'd0, 4'd3, 4'd0, 16'd0));
    emit(encode(OP_OUT, 4'd0, 4'd4, 4'd0, 16'd0));
    emit(encode(OP_OUT, 4'd0, 4'd5, 4'd0, 16'd0));
    emit(encode(OP_ADDI, 4'd0, 4'd0, 4'd0, a[15:0] | 16'h0001));
    emit(encode(OP_OUT, 4'd0, 4'd0, 4'd0, 16'd0));
    resetCore();
    expectOut(r6, "OR result");
    expectOut(r3, "ADD result");
    expectOut(r4, "SUB result");
    expectOut(r5, "AND result");
    expectOut('0, "register 0");
    checkQuiet(20);
  endtask

  task automatic storeLoad();
    logic [31:0] v;
    logic [31:0] base;
    logic [31:0] addrIdx;
    v       = randBits(16);
    base    = randBits(6) << 2;
    addrIdx = (base + 32'd8) >> 2;
    clearProgram();
    emit(encode(OP_ADDI, 4'd1, 4'd0, 4'd0, v[15:0]));
    emit(encode(OP_ADDI, 4'd2, 4'd0, 4'd0, base[15:0]));
    emit(encode(OP_SW, 4'd0, 4'd2, 4'd1, 16'd8));
    emit(encode(OP_LW, 4'd3, 4'd2, 4'd0, 16'd8));
    // load-use stall, then bypass from M
    emit(encode(OP_OUT, 4'd0, 4'd3, 4'd0, 16'd0));
    emit(encode(OP_ADD, 4'd4, 4'd3, 4'd3, 16'd0));
    emit(encode(OP_OUT, 4'd0, 4'd4, 4'd0, 16'd0));
    resetCore();
    expectOut(sext16(v[15:0]), "loaded word");
    expectOut(sext16(v[15:0]) + sext16(v[15:0]), "sum of loaded word");
    assert (dmem[addrIdx[7:0]] === sext16(v[15:0]))
      else failValue("dmem", dmem[addrIdx[7:0]], sext16(v[15:0]));
  endtask

  task automatic branchPaths();
    logic [31:0] x;
    x = randBits(16);
    clearProgram();
    emit(encode(OP_ADDI, 4'd1, 4'd0, 4'd0, x[15:0]));
    emit(encode(OP_ADDI, 4'd2, 4'd0, 4'd0, x[15:0]));
    emit(encode(OP_ADDI, 4'd3, 4'd0, 4'd0, x[15:0] ^ 16'h0001));
    emit(encode(OP_ADDI, 4'd4, 4'd0, 4'd0, ~x[15:0]));
    // taken branch skips both markers
    emit(encode(OP_BEQ, 4'd0, 4'd1, 4'd2, 16'd2));
    emit(encode(OP_OUT, 4'd0, 4'd4, 4'd0, 16'd0));
    emit(encode(OP_OUT, 4'd0, 4'd4, 4'd0, 16'd0));
    emit(encode(OP_OUT, 4'd0, 4'd1, 4'd0, 16'd0));
    // not taken
    emit(encode(OP_BEQ, 4'd0, 4'd1, 4'd3, 16'd1));
    emit(encode(OP_OUT, 4'd0, 4'd4, 4'd0, 16'd0));
    emit(encode(OP_OUT, 4'd0, 4'd3, 4'd0, 16'd0));
    resetCore();
    expectOut(sext16(x[15:0]), "taken branch target");
    expectOut(sext16(~x[15:0]), "not-taken fall through");
    expectOut(sext16(x[15:0] ^ 16'h0001), "last OUT");
    checkQuiet(20);
  endtask

  task automatic jumpSkip();
    logic [31:0] p;
    p = randBits(16);
    clearProgram();
    emit(encode(OP_ADDI, 4'd1, 4'd0, 4'd0, p[15:0]));
    emit(encode(OP_ADDI, 4'd2, 4'd0, 4'd0, ~p[15:0]));
    emit(encode(OP_JMP, 4'd0, 4'd0, 4'd0, 16'd1));
    emit(encode(OP_OUT, 4'd0, 4'd2, 4'd0, 16'd0));
    emit(encode(OP_OUT, 4'd0, 4'd1, 4'd0, 16'd0));
    resetCore();
    expectOut(sext16(p[15:0]), "jump target");
    checkQuiet(30);
  endtask

  initial begin
    reset = 1'b1;
    clearProgram();
    resetState();
    aluChain();
    storeLoad();
    branchPaths();
    jumpSkip();
    $display("NO ERRORS");
    $finish;
  end

endmodule

// ==== design/proc_decode.sv ====
// register file reads are combinational; W writes land at the clock edge
// branch and jump targets are both pcPlus4 + sext(imm) * 4

`timescale 1ns/1ns
`include "proc_defs.svh"

module proc_decode (
  input  logic                       clk,
  input  logic                       reset,
  input  proc_pkg::fetchToDecode_t   fToD,
  input  logic                       stallFD,
  input  logic                       squashX,
  input  proc_pkg::bypassSel_t       op0Sel,
  input  proc_pkg::bypassSel_t       op1Sel,
  input  logic [`PROC_XLEN-1:0]      bypX,
  input  logic [`PROC_XLEN-1:0]      bypM,
  input  logic [`PROC_XLEN-1:0]      bypW,
  input  proc_pkg::regWrite_t        wb,
  output logic [`PROC_RADDR_W-1:0]   rs,
  output logic [`PROC_RADDR_W-1:0]   rt,
  output logic                       rsUsed,
  output logic                       rtUsed,
  output logic                       jumpD,
  output logic [`PROC_XLEN-1:0]      jTarget,
  output proc_pkg::decodeToExecute_t dToX
);
  import proc_pkg::*;

  logic [`PROC_XLEN-1:0]    regFile [`PROC_NREGS];
  opcode_t                  opcode;
  logic [`PROC_RADDR_W-1:0] rd;
  logic [15:0]              imm;
  logic [`PROC_XLEN-1:0]    immSext;
  logic [`PROC_XLEN-1:0]    rfData0;
  logic [`PROC_XLEN-1:0]    rfData1;
  logic [`PROC_XLEN-1:0]    op0Byp;
  logic [`PROC_XLEN-1:0]    op1Byp;
  logic [`PROC_XLEN-1:0]    op1D;
  logic [`PROC_XLEN-1:0]    brTargetD;
  logic                     useImm;
  ctrl_t                    ctrlD;

  function automatic logic [`PROC_XLEN-1:0] bypassMux(
    input bypassSel_t            sel,
    input logic [`PROC_XLEN-1:0] fromRf,
    input logic [`PROC_XLEN-1:0] fromX,
    input logic [`PROC_XLEN-1:0] fromM,
    input logic [`PROC_XLEN-1:0] fromW
  );
    case (sel)
      BYP_X:   return fromX;
      BYP_M:   return fromM;
      BYP_W:   return fromW;
      default: return fromRf;
    endcase
  endfunction

  // ------------------------------------------------------------
  // unpack
  // ------------------------------------------------------------

  assign opcode  = opcode_t'(fToD.inst[31:28]);
  assign rd      = fToD.inst[27:24];
  assign rs      = fToD.inst[23:20];
  assign rt      = fToD.inst[19:16];
  assign imm     = fToD.inst[15:0];
  assign immSext = {{(`PROC_XLEN-16){imm[15]}}, imm};

  // control decode, everything zero for an invalid slot
  always_comb begin
    ctrlD       = '0;
    ctrlD.aluFn = ALU_ADD;
    ctrlD.rd    = rd;
    ctrlD.valid = fToD.valid;
    useImm      = 1'b0;
    rsUsed      = 1'b0;
    rtUsed      = 1'b0;
    jumpD       = 1'b0;
    if (fToD.valid) begin
      case (opcode)
        OP_ADD, OP_SUB, OP_AND, OP_OR: begin
          ctrlD.wbEn = 1'b1;
          rsUsed     = 1'b1;
          rtUsed     = 1'b1;
          case (opcode)
            OP_SUB:  ctrlD.aluFn = ALU_SUB;
            OP_AND:  ctrlD.aluFn = ALU_AND;
            OP_OR:   ctrlD.aluFn = ALU_OR;
            default: ctrlD.aluFn = ALU_ADD;
          endcase
        end
        OP_ADDI: begin
          ctrlD.wbEn = 1'b1;
          rsUsed     = 1'b1;
          useImm     = 1'b1;
        end
        OP_LW: begin
          ctrlD.wbEn    = 1'b1;
          ctrlD.memRead = 1'b1;
          rsUsed        = 1'b1;
          useImm        = 1'b1;
        end
        OP_SW: begin
          ctrlD.memWrite = 1'b1;
          rsUsed         = 1'b1;
          rtUsed         = 1'b1;
          useImm         = 1'b1;
        end
        OP_BEQ: begin
          ctrlD.isBranch = 1'b1;
          rsUsed         = 1'b1;
          rtUsed         = 1'b1;
        end
        OP_JMP: jumpD = 1'b1;
        OP_OUT: begin
          ctrlD.aluFn = ALU_PASS1;
          ctrlD.outEn = 1'b1;
          rsUsed      = 1'b1;
        end
        default: ;
      endcase
    end
  end

  // ------------------------------------------------------------
  // register file and operands
  // ------------------------------------------------------------

  always_ff @(posedge clk) begin
    if (wb.en && wb.addr != '0) begin
      regFile[wb.addr] <= wb.data;
    end
  end

  // r0 always reads zero
  assign rfData0 = (rs == '0) ? '0 : regFile[rs];
  assign rfData1 = (rt == '0) ? '0 : regFile[rt];

  assign op0Byp = bypassMux(op0Sel, rfData0, bypX, bypM, bypW);
  assign op1Byp = bypassMux(op1Sel, rfData1, bypX, bypM, bypW);
  assign op1D   = useImm ? immSext : op1Byp;

  assign brTargetD = fToD.pcPlus4 + {immSext[`PROC_XLEN-3:0], 2'b00};
  assign jTarget   = fToD.pcPlus4 + {immSext[`PROC_XLEN-3:0], 2'b00};

  // D-to-X register, bubble on stall or squash
  always_ff @(posedge clk) begin
    if (reset || stallFD || squashX) begin
      dToX.ctrl <= '0;
    end else begin
      dToX.ctrl <= ctrlD;
    end
    dToX.op0       <= op0Byp;
    dToX.op1       <= op1D;
    dToX.storeData <= op1Byp;
    dToX.brTarget  <= brTargetD;
  end

endmodule

// ==== design/proc_execute.sv ====
// data memory request leaves from X; the response is expected in M
// the memory address is always the ALU sum of rs and the immediate

`timescale 1ns/1ns
`include "proc_defs.svh"

module proc_execute (
  input  logic                       clk,
  input  logic                       reset,
  input  proc_pkg::decodeToExecute_t dToX,
  output logic                       branchTaken,
  output logic [`PROC_XLEN-1:0]      brTarget,
  output proc_pkg::ctrl_t            xCtrl,
  output logic [`PROC_XLEN-1:0]      bypX,
  output logic                       dmemReq,
  output logic                       dmemWrite,
  output logic [`PROC_XLEN-1:0]      dmemAddr,
  output logic [`PROC_XLEN-1:0]      dmemWriteData,
  output proc_pkg::execToMem_t       xToM
);
  import proc_pkg::*;

  logic [`PROC_XLEN-1:0] aluResult;

  // ALU
  always_comb begin
    case (dToX.ctrl.aluFn)
      ALU_ADD:   aluResult = dToX.op0 + dToX.op1;
      ALU_SUB:   aluResult = dToX.op0 - dToX.op1;
      ALU_AND:   aluResult = dToX.op0 & dToX.op1;
      ALU_OR:    aluResult = dToX.op0 | dToX.op1;
      ALU_PASS1: aluResult = dToX.op0;
      default:   aluResult = dToX.op0;
    endcase
  end

  // BEQ resolves here
  assign branchTaken = dToX.ctrl.valid && dToX.ctrl.isBranch && (dToX.op0 == dToX.op1);
  assign brTarget    = dToX.brTarget;

  assign xCtrl = dToX.ctrl;
  assign bypX  = aluResult;

  // ------------------------------------------------------------
  // data memory request
  // ------------------------------------------------------------

  assign dmemReq       = dToX.ctrl.memRead || dToX.ctrl.memWrite;
  assign dmemWrite     = dToX.ctrl.memWrite;
  assign dmemAddr      = aluResult;
  assign dmemWriteData = dToX.storeData;

  // X-to-M register
  always_ff @(posedge clk) begin
    if (reset) begin
      xToM.ctrl <= '0;
    end else begin
      xToM.ctrl <= dToX.ctrl;
    end
    xToM.result <= aluResult;
  end

endmodule

// ==== design/proc_fetch.sv ====
// instruction memory read is combinational from imemAddr
// the PC holds while stallFD is high; branch and jump redirect it

`timescale 1ns/1ns
`include "proc_defs.svh"

module proc_fetch (
  input  logic                     clk,
  input  logic                     reset,
  input  logic                     stallFD,
  input  logic                     squashD,
  input  proc_pkg::pcSel_t         pcSel,
  input  logic [`PROC_XLEN-1:0]    brTarget,
  input  logic [`PROC_XLEN-1:0]    jTarget,
  output logic [`PROC_XLEN-1:0]    imemAddr,
  input  logic [`PROC_XLEN-1:0]    imemData,
  output proc_pkg::fetchToDecode_t fToD
);
  import proc_pkg::*;

  logic [`PROC_XLEN-1:0] pc;
  logic [`PROC_XLEN-1:0] pcPlus4;
  logic [`PROC_XLEN-1:0] pcNext;

  assign pcPlus4  = pc + `PROC_XLEN'd4;
  assign imemAddr = pc;

  // next PC select
  always_comb begin
    case (pcSel)
      PC_BRANCH: pcNext = brTarget;
      PC_JUMP:   pcNext = jTarget;
      default:   pcNext = pcPlus4;
    endcase
  end

  always_ff @(posedge clk) begin
    if (reset) begin
      pc <= `PROC_RESET_PC;
    end else if (!stallFD) begin
      pc <= pcNext;
    end
  end

  // F-to-D register, valid cleared on squash
  always_ff @(posedge clk) begin
    if (reset || squashD) begin
      fToD.valid <= 1'b0;
    end else if (!stallFD) begin
      fToD.valid <= 1'b1;
    end
    if (!stallFD) begin
      fToD.pcPlus4 <= pcPlus4;
      fToD.inst    <= imemData;
    end
  end

endmodule

// ==== design/proc_hazard.sv ====
// purely combinational; priority is branch, then load-use, then jump
// bypass picks the youngest of X, M and W that writes the source

`timescale 1ns/1ns
`include "proc_defs.svh"

module proc_hazard (
  input  logic [`PROC_RADDR_W-1:0] rs,
  input  logic [`PROC_RADDR_W-1:0] rt,
  input  logic                     rsUsed,
  input  logic                     rtUsed,
  input  proc_pkg::ctrl_t          xCtrl,
  input  proc_pkg::ctrl_t          mCtrl,
  input  proc_pkg::ctrl_t          wCtrl,
  input  logic                     branchTaken,
  input  logic                     jumpD,
  output logic                     stallFD,
  output logic                     squashD,
  output logic                     squashX,
  output proc_pkg::bypassSel_t     op0Sel,
  output proc_pkg::bypassSel_t     op1Sel,
  output proc_pkg::pcSel_t         pcSel
);
  import proc_pkg::*;

  logic loadUse;

  function automatic logic writesReg(input ctrl_t c, input logic [`PROC_RADDR_W-1:0] src);
    return c.valid && c.wbEn && (c.rd == src);
  endfunction

  function automatic bypassSel_t pickSource(
    input logic [`PROC_RADDR_W-1:0] src,
    input logic                     used,
    input ctrl_t                    x,
    input ctrl_t                    m,
    input ctrl_t                    w
  );
    if (!used || src == '0) return BYP_RF;
    if (writesReg(x, src)) return BYP_X;
    if (writesReg(m, src)) return BYP_M;
    if (writesReg(w, src)) return BYP_W;
    return BYP_RF;
  endfunction

  assign op0Sel = pickSource(rs, rsUsed, xCtrl, mCtrl, wCtrl);
  assign op1Sel = pickSource(rt, rtUsed, xCtrl, mCtrl, wCtrl);

  // load in X feeding D cannot bypass in time
  assign loadUse = xCtrl.valid && xCtrl.memRead && xCtrl.rd != '0 &&
                   ((rsUsed && rs == xCtrl.rd) || (rtUsed && rt == xCtrl.rd));

  always_comb begin
    stallFD = 1'b0;
    squashD = 1'b0;
    squashX = 1'b0;
    pcSel   = PC_PLUS4;
    if (branchTaken) begin
      // kills both younger instructions
      squashD = 1'b1;
      squashX = 1'b1;
      pcSel   = PC_BRANCH;
    end else if (loadUse) begin
      stallFD = 1'b1;
      squashX = 1'b1;
    end else if (jumpD) begin
      squashD = 1'b1;
      pcSel   = PC_JUMP;
    end
  end

endmodule

// ==== design/proc_memwb.sv ====
// load data arrives on dmemReadData during M
// toMngrValid pulses for one cycle per OUT in W

`timescale 1ns/1ns
`include "proc_defs.svh"

module proc_memwb (
  input  logic                  clk,
  input  logic                  reset,
  input  proc_pkg::execToMem_t  xToM,
  input  logic [`PROC_XLEN-1:0] dmemReadData,
  output proc_pkg::ctrl_t       mCtrl,
  output proc_pkg::ctrl_t       wCtrl,
  output logic [`PROC_XLEN-1:0] bypM,
  output logic [`PROC_XLEN-1:0] bypW,
  output proc_pkg::regWrite_t   wb,
  output logic                  toMngrValid,
  output logic [`PROC_XLEN-1:0] toMngrData
);
  import proc_pkg::*;

  memToWb_t              mToW;
  logic [`PROC_XLEN-1:0] mResult;

  // M stage result select
  assign mResult = xToM.ctrl.memRead ? dmemReadData : xToM.result;
  assign mCtrl   = xToM.ctrl;
  assign bypM    = mResult;

  always_ff @(posedge clk) begin
    if (reset) begin
      mToW.ctrl <= '0;
    end else begin
      mToW.ctrl <= xToM.ctrl;
    end
    mToW.result <= mResult;
  end

  // writeback
  assign wCtrl = mToW.ctrl;
  assign bypW  = mToW.result;
  assign wb    = '{en:   mToW.ctrl.valid && mToW.ctrl.wbEn,
                   addr: mToW.ctrl.rd,
                   data: mToW.result};

  // OUT carries rs through PASS1
  assign toMngrValid = mToW.ctrl.valid && mToW.ctrl.outEn;
  assign toMngrData  = mToW.result;

endmodule

// ==== design/proc_pkg.sv ====
// types shared by the pipeline stages
// instruction word is opcode[31:28] rd[27:24] rs[23:20] rt[19:16] imm[15:0]

`include "proc_defs.svh"

package proc_pkg;

  // opcode 0 is NOP so zeroed memory executes harmlessly
  typedef enum logic [3:0] {
    OP_NOP  = 4'd0,
    OP_ADD  = 4'd1,
    OP_SUB  = 4'd2,
    OP_AND  = 4'd3,
    OP_OR   = 4'd4,
    OP_ADDI = 4'd5,
    OP_LW   = 4'd6,
    OP_SW   = 4'd7,
    OP_BEQ  = 4'd8,
    OP_JMP  = 4'd9,
    OP_OUT  = 4'd10
  } opcode_t;

  // PASS1 forwards the first operand (rs)
  typedef enum logic [2:0] {
    ALU_ADD   = 3'd0,
    ALU_SUB   = 3'd1,
    ALU_AND   = 3'd2,
    ALU_OR    = 3'd3,
    ALU_PASS1 = 3'd4
  } aluFn_t;

  typedef enum logic [1:0] {
    BYP_RF = 2'd0,
    BYP_X  = 2'd1,
    BYP_M  = 2'd2,
    BYP_W  = 2'd3
  } bypassSel_t;

  typedef enum logic [1:0] {
    PC_PLUS4  = 2'd0,
    PC_BRANCH = 2'd1,
    PC_JUMP   = 2'd2
  } pcSel_t;

  typedef struct packed {
    aluFn_t                   aluFn;
    logic [`PROC_RADDR_W-1:0] rd;
    logic                     wbEn;
    logic                     memRead;
    logic                     memWrite;
    logic                     outEn;
    logic                     isBranch;
    logic                     valid;
  } ctrl_t;

  typedef struct packed {
    logic                  valid;
    logic [`PROC_XLEN-1:0] pcPlus4;
    logic [`PROC_XLEN-1:0] inst;
  } fetchToDecode_t;

  typedef struct packed {
    ctrl_t                 ctrl;
    logic [`PROC_XLEN-1:0] op0;
    logic [`PROC_XLEN-1:0] op1;
    logic [`PROC_XLEN-1:0] storeData;
    logic [`PROC_XLEN-1:0] brTarget;
  } decodeToExecute_t;

  typedef struct packed {
    ctrl_t                 ctrl;
    logic [`PROC_XLEN-1:0] result;
  } execToMem_t;

  typedef struct packed {
    ctrl_t                 ctrl;
    logic [`PROC_XLEN-1:0] result;
  } memToWb_t;

  typedef struct packed {
    logic                     en;
    logic [`PROC_RADDR_W-1:0] addr;
    logic [`PROC_XLEN-1:0]    data;
  } regWrite_t;

endpackage

// ==== design/proc_top.sv ====
// five-stage core, memories and manager sink live outside
// no back-pressure; dmemReadData must be valid the cycle after dmemReq

`timescale 1ns/1ns
`include "proc_defs.svh"

module proc_top (
  input  logic                  clk,
  input  logic                  reset,
  output logic [`PROC_XLEN-1:0] imemAddr,
  input  logic [`PROC_XLEN-1:0] imemData,
  output logic                  dmemReq,
  output logic                  dmemWrite,
  output logic [`PROC_XLEN-1:0] dmemAddr,
  output logic [`PROC_XLEN-1:0] dmemWriteData,
  input  logic [`PROC_XLEN-1:0] dmemReadData,
  output logic                  toMngrValid,
  output logic [`PROC_XLEN-1:0] toMngrData
);
  import proc_pkg::*;

  fetchToDecode_t           fToD;
  decodeToExecute_t         dToX;
  execToMem_t               xToM;
  regWrite_t                wb;
  ctrl_t                    xCtrl;
  ctrl_t                    mCtrl;
  ctrl_t                    wCtrl;
  bypassSel_t               op0Sel;
  bypassSel_t               op1Sel;
  pcSel_t                   pcSel;
  logic                     stallFD;
  logic                     squashD;
  logic                     squashX;
  logic                     branchTaken;
  logic                     jumpD;
  logic                     rsUsed;
  logic                     rtUsed;
  logic [`PROC_RADDR_W-1:0] rs;
  logic [`PROC_RADDR_W-1:0] rt;
  logic [`PROC_XLEN-1:0]    brTarget;
  logic [`PROC_XLEN-1:0]    jTarget;
  logic [`PROC_XLEN-1:0]    bypX;
  logic [`PROC_XLEN-1:0]    bypM;
  logic [`PROC_XLEN-1:0]    bypW;

  // ------------------------------------------------------------
  // pipeline stages
  // ------------------------------------------------------------

  proc_fetch fetch (
    .clk      (clk),
    .reset    (reset),
    .stallFD  (stallFD),
    .squashD  (squashD),
    .pcSel    (pcSel),
    .brTarget (brTarget),
    .jTarget  (jTarget),
    .imemAddr (imemAddr),
    .imemData (imemData),
    .fToD     (fToD)
  );

  proc_decode decode (
    .clk     (clk),
    .reset   (reset),
    .fToD    (fToD),
    .stallFD (stallFD),
    .squashX (squashX),
    .op0Sel  (op0Sel),
    .op1Sel  (op1Sel),
    .bypX    (bypX),
    .bypM    (bypM),
    .bypW    (bypW),
    .wb      (wb),
    .rs      (rs),
    .rt      (rt),
    .rsUsed  (rsUsed),
    .rtUsed  (rtUsed),
    .jumpD   (jumpD),
    .jTarget (jTarget),
    .dToX    (dToX)
  );

  proc_execute execute (
    .clk           (clk),
    .reset         (reset),
    .dToX          (dToX),
    .branchTaken   (branchTaken),
    .brTarget      (brTarget),
    .xCtrl         (xCtrl),
    .bypX          (bypX),
    .dmemReq       (dmemReq),
    .dmemWrite     (dmemWrite),
    .dmemAddr      (dmemAddr),
    .dmemWriteData (dmemWriteData),
    .xToM          (xToM)
  );

  proc_memwb memwb (
    .clk          (clk),
    .reset        (reset),
    .xToM         (xToM),
    .dmemReadData (dmemReadData),
    .mCtrl        (mCtrl),
    .wCtrl        (wCtrl),
    .bypM         (bypM),
    .bypW         (bypW),
    .wb           (wb),
    .toMngrValid  (toMngrValid),
    .toMngrData   (toMngrData)
  );

  // stalls, squashes and bypass selects
  proc_hazard hazard (
    .rs          (rs),
    .rt          (rt),
    .rsUsed      (rsUsed),
    .rtUsed      (rtUsed),
    .xCtrl       (xCtrl),
    .mCtrl       (mCtrl),
    .wCtrl       (wCtrl),
    .branchTaken (branchTaken),
    .jumpD       (jumpD),
    .stallFD     (stallFD),
    .squashD     (squashD),
    .squashX     (squashX),
    .op0Sel      (op0Sel),
    .op1Sel      (op1Sel),
    .pcSel       (pcSel)
  );

endmodule

// ==== include/proc_defs.svh ====
// core-wide widths and the reset vector
// 16 registers with register 0 fixed at zero; data and addresses are one word

`ifndef PROC_DEFS_SVH
`define PROC_DEFS_SVH

// data and address width
`define PROC_XLEN 32

// architectural registers
`define PROC_NREGS 16
`define PROC_RADDR_W 4

// first fetch address after reset
`define PROC_RESET_PC 32'h1000

`endif

// ==== project.f ====
+incdir+include
design/proc_pkg.sv
design/proc_fetch.sv
design/proc_decode.sv
design/proc_execute.sv
design/proc_memwb.sv
design/proc_hazard.sv
design/proc_top.sv
bench/proc_props.sv
bench/proc_tb.sv

// ==== run.sh ====
#!/bin/sh
# builds the testbench with Verilator, runs it and checks the log
cd "$(dirname "$0")" || exit 1
rm -f sim.log
verilator --binary --timing --assert --timescale 1ns/1ns \
  -f project.f --top-module proc_tb -o proc_sim \
  && ./obj_dir/proc_sim > sim.log 2>&1
cat sim.log 2>/dev/null
grep -q "NO ERRORS" sim.log && echo "simulation passed" || { echo "simulation failed"; exit 1; }
